// File: rtl/fir_defs.svh
`ifndef FIR_DEFS_SVH
`define FIR_DEFS_SVH

// datapath and register port widths
`define FIR_DATA_W 32
`define FIR_ADDR_W 12

// filter length, also the depth of the sample history
`define FIR_TAPS 11

// register map
`define FIR_REG_CTRL     12'h000
`define FIR_REG_LEN      12'h010
`define FIR_REG_TAP_BASE 12'h080

`endif

// File: rtl/fir_pkg.sv
`include "fir_defs.svh"

package fir_pkg;

    typedef logic [`FIR_DATA_W-1:0] data_t;
    typedef logic [`FIR_ADDR_W-1:0] addr_t;
    typedef logic [3:0]             tap_idx_t;

    // engine sequencing
    typedef enum logic [2:0] {
        st_idle,
        st_clear,
        st_wait_sample,
        st_mac,
        st_hand_off
    } engine_state_e;

endpackage

// File: rtl/fir_cfg_if.sv
`timescale 1ns/1ps

interface fir_cfg_if;
    import fir_pkg::*;

    // run control
    logic     start;
    data_t    run_len;
    logic     run_done;

    // coefficient lookup, answered in the same cycle
    tap_idx_t tap_idx;
    data_t    tap_coef;

    modport regs (
        output start,
        output run_len,
        output tap_coef,
        input  tap_idx,
        input  run_done
    );

    modport engine (
        input  start,
        input  run_len,
        input  tap_coef,
        output tap_idx,
        output run_done
    );
endinterface

// File: rtl/fir_sample_if.sv
`timescale 1ns/1ps

interface fir_sample_if;
    import fir_pkg::*;

    logic     clear;
    logic     want;
    logic     got;

    // history read, offset 0 is the newest sample
    tap_idx_t rd_offset;
    data_t    rd_data;

    modport buffer (
        input  clear,
        input  want,
        input  rd_offset,
        output got,
        output rd_data
    );

    modport engine (
        output clear,
        output want,
        output rd_offset,
        input  got,
        input  rd_data
    );
endinterface

// File: rtl/fir_axil_regs.sv
`timescale 1ns/1ps
`include "fir_defs.svh"

module fir_axil_regs (
    input  logic           axis_clk,
    input  logic           axis_rst_n,
    input  logic           awvalid,
    input  fir_pkg::addr_t awaddr,
    input  logic           wvalid,
    input  fir_pkg::data_t wdata,
    output logic           awready,
    output logic           wready,
    input  logic           arvalid,
    input  fir_pkg::addr_t araddr,
    output logic           arready,
    output logic           rvalid,
    input  logic           rready,
    output fir_pkg::data_t rdata,
    fir_cfg_if.regs        cfg
);
    import fir_pkg::*;

    addr_t rd_addr;
    data_t coef [`FIR_TAPS];
    logic  ap_done;
    logic  ap_idle;
    logic  wr_fire;
    logic  rd_done;

    // word aligned and inside the coefficient window
    function automatic logic is_tap(input addr_t addr);
        return addr >= `FIR_REG_TAP_BASE && addr < `FIR_REG_TAP_BASE + 4 * `FIR_TAPS
            && addr[1:0] == 2'b00;
    endfunction

    function automatic tap_idx_t tap_of(input addr_t addr);
        addr_t offs;
        offs = addr - `FIR_REG_TAP_BASE;
        return offs[5:2];
    endfunction

    ////////////////////////////////////////////////////////////
    // write channel, both readies pulse together
    assign wr_fire = awready && wready;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !awready && !wready;
            wready  <= awvalid && wvalid && !awready && !wready;
        end
    end

    ////////////////////////////////////////////////////////////
    // read channel, rvalid held until rready
    assign rd_done = rvalid && rready;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (arvalid && arready) begin
                rvalid <= 1'b1;
            end else if (rd_done) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (arvalid && arready) begin
            rd_addr <= araddr;
        end
    end

    ////////////////////////////////////////////////////////////
    // 0x00 control and 0x10 run length
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ap_idle     <= 1'b1;
            ap_done     <= 1'b0;
            cfg.start   <= 1'b0;
            cfg.run_len <= '0;
        end else begin
            cfg.start <= 1'b0;
            if (cfg.run_done) begin
                ap_idle <= 1'b1;
                ap_done <= 1'b1;
            end else if (wr_fire && ap_idle && awaddr == `FIR_REG_CTRL && wdata[0]) begin
                cfg.start <= 1'b1;
                ap_idle   <= 1'b0;
                ap_done   <= 1'b0;
            end else if (rd_done && rd_addr == `FIR_REG_CTRL) begin
                // done is read-to-clear
                ap_done <= 1'b0;
            end
            if (wr_fire && ap_idle && awaddr == `FIR_REG_LEN) begin
                cfg.run_len <= wdata;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // 0x80 onward, one coefficient per word
    always_ff @(posedge axis_clk) begin
        if (wr_fire && ap_idle && is_tap(awaddr)) begin
            coef[tap_of(awaddr)] <= wdata;
        end
    end

    assign cfg.tap_coef = coef[cfg.tap_idx];

    // read data from the latched address
    always_comb begin
        rdata = '0;
        if (rd_addr == `FIR_REG_CTRL) begin
            rdata = {{(`FIR_DATA_W-3){1'b0}}, ap_idle, ap_done, 1'b0};
        end else if (rd_addr == `FIR_REG_LEN) begin
            rdata = cfg.run_len;
        end else if (is_tap(rd_addr)) begin
            rdata = coef[tap_of(rd_addr)];
        end
    end
endmodule

// File: rtl/fir_sample_buffer.sv
`timescale 1ns/1ps
`include "fir_defs.svh"

module fir_sample_buffer (
    input  logic           axis_clk,
    input  logic           axis_rst_n,
    input  logic           ss_tvalid,
    input  fir_pkg::data_t ss_tdata,
    output logic           ss_tready,
    fir_sample_if.buffer   smp
);
    import fir_pkg::*;

    data_t    hist [`FIR_TAPS];
    tap_idx_t wr_ptr;
    tap_idx_t newest;
    tap_idx_t rd_slot;
    logic     take;

    assign take    = ss_tready && ss_tvalid;
    assign smp.got = take;

    // ready for one beat per request
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ss_tready <= 1'b0;
            wr_ptr    <= '0;
        end else begin
            ss_tready <= smp.want && ss_tvalid && !ss_tready;
            if (smp.clear) begin
                wr_ptr <= '0;
            end else if (take) begin
                wr_ptr <= (wr_ptr == tap_idx_t'(`FIR_TAPS - 1)) ? '0 : wr_ptr + 1'b1;
            end
        end
    end

    // whole history zeroed at run start
    always_ff @(posedge axis_clk) begin
        if (smp.clear) begin
            for (int i = 0; i < `FIR_TAPS; i++) begin
                hist[i] <= '0;
            end
        end else if (take) begin
            hist[wr_ptr] <= ss_tdata;
        end
    end

    // walk back from the newest entry, wrapping
    always_comb begin
        newest = (wr_ptr == '0) ? tap_idx_t'(`FIR_TAPS - 1) : wr_ptr - 1'b1;
        if (newest >= smp.rd_offset) begin
            rd_slot = newest - smp.rd_offset;
        end else begin
            rd_slot = newest + tap_idx_t'(`FIR_TAPS) - smp.rd_offset;
        end
    end

    assign smp.rd_data = hist[rd_slot];
endmodule

// File: rtl/fir_mac_engine.sv
`timescale 1ns/1ps
`include "fir_defs.svh"

module fir_mac_engine (
    input  logic           axis_clk,
    input  logic           axis_rst_n,
    fir_cfg_if.engine      cfg,
    fir_sample_if.engine   smp,
    input  logic           out_full,
    input  logic           last_sent,
    output fir_pkg::data_t result,
    output logic           result_last,
    output logic           result_load
);
    import fir_pkg::*;

    engine_state_e state;
    engine_state_e state_nx;
    tap_idx_t      tap_cnt;
    data_t         acc;
    data_t         out_cnt;
    logic          at_last_tap;

    assign at_last_tap = tap_cnt == tap_idx_t'(`FIR_TAPS - 1);

    // same index addresses coefficient and history
    assign cfg.tap_idx   = tap_cnt;
    assign smp.rd_offset = tap_cnt;
    assign smp.clear     = state == st_clear;
    assign smp.want      = state == st_wait_sample;

    // run ends when the final beat leaves the output stage
    assign cfg.run_done = last_sent;

    assign result      = acc;
    assign result_last = (out_cnt + 1'b1) == cfg.run_len;
    assign result_load = (state == st_hand_off) && !out_full;

    always_comb begin
        state_nx = state;
        case (state)
            st_idle:        if (cfg.start) state_nx = st_clear;
            st_clear:       state_nx = st_wait_sample;
            st_wait_sample: if (smp.got) state_nx = st_mac;
            st_mac:         if (at_last_tap) state_nx = st_hand_off;
            st_hand_off: begin
                if (result_load) begin
                    state_nx = result_last ? st_idle : st_wait_sample;
                end
            end
            default:        state_nx = st_idle;
        endcase
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state   <= st_idle;
            tap_cnt <= '0;
            out_cnt <= '0;
        end else begin
            state <= state_nx;
            if (state == st_clear) begin
                out_cnt <= '0;
            end else if (result_load) begin
                out_cnt <= out_cnt + 1'b1;
            end
            // one tap per cycle, back to zero after the last
            if (state == st_mac) begin
                tap_cnt <= at_last_tap ? '0 : tap_cnt + 1'b1;
            end
        end
    end

    // products and sum wrap at the data width
    always_ff @(posedge axis_clk) begin
        if (state == st_wait_sample) begin
            acc <= '0;
        end else if (state == st_mac) begin
            acc <= acc + cfg.tap_coef * smp.rd_data;
        end
    end
endmodule

// File: rtl/fir_stream_out.sv
`timescale 1ns/1ps

module fir_stream_out (
    input  logic           axis_clk,
    input  logic           axis_rst_n,
    input  fir_pkg::data_t result,
    input  logic           result_last,
    input  logic           result_load,
    output logic           out_full,
    output logic           last_sent,
    input  logic           sm_tready,
    output logic           sm_tvalid,
    output logic           sm_tlast,
    output fir_pkg::data_t sm_tdata
);
    logic sent;

    assign sent      = sm_tvalid && sm_tready;
    assign out_full  = sm_tvalid;
    assign last_sent = sent && sm_tlast;

    // load only happens while empty, so no load and send overlap
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end else if (result_load) begin
            sm_tvalid <= 1'b1;
            sm_tlast  <= result_last;
        end else if (sent) begin
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (result_load) begin
            sm_tdata <= result;
        end
    end
endmodule

// File: rtl/fir_top.sv
`timescale 1ns/1ps

module fir_top (
    input  logic           axis_clk,
    input  logic           axis_rst_n,
    input  logic           awvalid,
    input  fir_pkg::addr_t awaddr,
    input  logic           wvalid,
    input  fir_pkg::data_t wdata,
    output logic           awready,
    output logic           wready,
    input  logic           arvalid,
    input  fir_pkg::addr_t araddr,
    output logic           arready,
    output logic           rvalid,
    input  logic           rready,
    output fir_pkg::data_t rdata,
    input  logic           ss_tvalid,
    input  fir_pkg::data_t ss_tdata,
    input  logic           ss_tlast,
    output logic           ss_tready,
    output logic           sm_tvalid,
    output fir_pkg::data_t sm_tdata,
    output logic           sm_tlast,
    input  logic           sm_tready
);
    import fir_pkg::*;

    data_t result;
    logic  result_last;
    logic  result_load;
    logic  out_full;
    logic  last_sent;

    fir_cfg_if    cfg_bus ();
    fir_sample_if smp_bus ();

    fir_axil_regs u_regs (.cfg(cfg_bus.regs), .*);

    // end of run comes from the programmed length, ss_tlast stays unused
    fir_sample_buffer u_buffer (.smp(smp_bus.buffer), .*);

    fir_mac_engine u_engine (.cfg(cfg_bus.engine), .smp(smp_bus.engine), .*);

    fir_stream_out u_stream_out (.*);
endmodule

// File: sim/tb_fir.sv
`timescale 1ns/1ps
`include "fir_defs.svh"

module tb_fir;
    import fir_pkg::*;

    logic axis_clk;
    logic axis_rst_n;
    logic awvalid, wvalid, awready, wready;
    logic arvalid, arready, rvalid, rready;
    addr_t awaddr, araddr;
    data_t wdata, rdata;
    logic ss_tvalid, ss_tlast, ss_tready;
    data_t ss_tdata, sm_tdata;
    logic sm_tvalid, sm_tlast;
    logic sm_tready = 1'b0;

    logic [31:0] lfsr;
    logic        ready_mode;
    int          rx_cnt;
    int          exp_len;
    string       cur_test;
    data_t       coef_m [`FIR_TAPS];
    data_t       x_q [$];
    data_t       exp_q [$];
    data_t       rd_v;

    fir_top dut_i (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n),
        .awvalid(awvalid), .awaddr(awaddr), .wvalid(wvalid), .wdata(wdata),
        .awready(awready), .wready(wready),
        .arvalid(arvalid), .araddr(araddr), .arready(arready),
        .rvalid(rvalid), .rready(rready), .rdata(rdata),
        .ss_tvalid(ss_tvalid), .ss_tdata(ss_tdata), .ss_tlast(ss_tlast),
        .ss_tready(ss_tready),
        .sm_tvalid(sm_tvalid), .sm_tdata(sm_tdata), .sm_tlast(sm_tlast),
        .sm_tready(sm_tready)
    );

    initial begin
        axis_clk = 1'b0;
        forever #5 axis_clk = ~axis_clk;
    end

    ////////////////////////////////////////////////////////////
    // random source and reference model

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output data_t val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[`FIR_DATA_W-2:0], lfsr[0]};
        end
    endtask

    // samples before the run count as zero
    function automatic data_t fir_ref(input int n);
        data_t sum;
        sum = '0;
        for (int k = 0; k < `FIR_TAPS; k++) begin
            if (n - k >= 0) begin
                sum = sum + coef_m[k] * x_q[n-k];
            end
        end
        return sum;
    endfunction

    ////////////////////////////////////////////////////////////
    // reporting

    task automatic report_failure(input string what);
        $display("failure in %s: %s", cur_test, what);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // bus tasks entered and left 1 ns after a rising edge

    task automatic write_reg(input addr_t addr, input data_t val);
        logic done;
        done    = 1'b0;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = val;
        for (int i = 0; i < 50 && !done; i++) begin
            @(posedge axis_clk);
            done = awready && wready;
        end
        if (!done) report_failure("register write was never accepted");
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic read_reg(input addr_t addr, output data_t val);
        logic done;
        done    = 1'b0;
        arvalid = 1'b1;
        araddr  = addr;
        for (int i = 0; i < 50 && !done; i++) begin
            @(posedge axis_clk);
            done = arready;
        end
        if (!done) report_failure("register read address was never accepted");
        #1;
        arvalid = 1'b0;
        rready  = 1'b1;
        done    = 1'b0;
        for (int i = 0; i < 50 && !done; i++) begin
            @(posedge axis_clk);
            done = rvalid;
            val  = rdata;
        end
        if (!done) report_failure("read data never became valid");
        #1;
        rready = 1'b0;
    endtask

    task automatic send_sample(input data_t val);
        logic taken;
        taken     = 1'b0;
        ss_tvalid = 1'b1;
        ss_tdata  = val;
        for (int i = 0; i < 200 && !taken; i++) begin
            @(posedge axis_clk);
            taken = ss_tready;
        end
        if (!taken) report_failure("sample was never accepted on the slave stream");
        #1;
        ss_tvalid = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // output side

    // ready mode latched at the edge so lfsr steps never interleave
    always @(posedge axis_clk) begin : ready_drive
        logic  mode;
        data_t bit_v;
        mode = ready_mode;
        #1;
        if (mode) begin
            take_bits(1, bit_v);
            sm_tready = bit_v[0];
        end else begin
            sm_tready = 1'b1;
        end
    end

    always @(posedge axis_clk) begin
        if (axis_rst_n && sm_tvalid && sm_tready) begin
            if (exp_q.size() == 0) begin
                report_failure("master stream sent an output that was not expected");
            end else begin
                check_value({cur_test, " data"}, exp_q.pop_front(), sm_tdata);
                check_value({cur_test, " last"}, data_t'(rx_cnt == exp_len - 1),
                            data_t'(sm_tlast));
                rx_cnt++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // test sequences

    task automatic load_coefs(input string name);
        data_t c;
        cur_test = name;
        for (int k = 0; k < `FIR_TAPS; k++) begin
            take_bits(32, c);
            coef_m[k] = c;
            write_reg(addr_t'(`FIR_REG_TAP_BASE + 4 * k), c);
        end
        for (int k = 0; k < `FIR_TAPS; k++) begin
            read_reg(addr_t'(`FIR_REG_TAP_BASE + 4 * k), c);
            check_value({name, " coef readback"}, coef_m[k], c);
        end
    endtask

    task automatic run_filter(input string name, input int len, input logic rand_ready);
        data_t v;
        cur_test = name;
        x_q.delete();
        for (int i = 0; i < len; i++) begin
            take_bits(32, v);
            x_q.push_back(v);
        end
        for (int n = 0; n < len; n++) begin
            exp_q.push_back(fir_ref(n));
        end
        rx_cnt  = 0;
        exp_len = len;
        write_reg(`FIR_REG_LEN, data_t'(len));
        ready_mode = rand_ready;
        write_reg(`FIR_REG_CTRL, 32'h1);
        for (int i = 0; i < len; i++) begin
            send_sample(x_q[i]);
        end
        for (int i = 0; i < 5000 && rx_cnt < len; i++) begin
            @(posedge axis_clk);
            #1;
        end
        if (rx_cnt < len) report_failure("not all filter outputs arrived");
        ready_mode = 1'b0;
        // done is read-to-clear while idle stays set
        read_reg(`FIR_REG_CTRL, v);
        check_value({name, " ctrl after run"}, 32'd6, v);
        read_reg(`FIR_REG_CTRL, v);
        check_value({name, " ctrl second read"}, 32'd4, v);
    endtask

    initial begin
        axis_rst_n = 1'b0;
        {awvalid, wvalid, arvalid, rready} = '0;
        awaddr     = '0;
        araddr     = '0;
        wdata      = '0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        ss_tlast   = 1'b0;
        lfsr       = 32'h797;
        ready_mode = 1'b0;
        rx_cnt     = 0;
        exp_len    = 0;
        cur_test   = "reset";
        repeat (4) @(posedge axis_clk);
        #1;
        axis_rst_n = 1'b1;

        read_reg(`FIR_REG_CTRL, rd_v);
        check_value("reset ctrl", 32'd4, rd_v);

        load_coefs("config");
        write_reg(`FIR_REG_LEN, 32'd40);
        read_reg(`FIR_REG_LEN, rd_v);
        check_value("config length readback", 32'd40, rd_v);

        run_filter("run_ready_high", 40, 1'b0);
        run_filter("run_ready_random", 40, 1'b1);

        // fresh coefficients with the history starting from zero again
        load_coefs("second config");
        run_filter("second_run", 15, 1'b0);

        $display("All checks passed");
        $finish;
    end
endmodule

// File: fir.f
+incdir+rtl
rtl/fir_pkg.sv
rtl/fir_cfg_if.sv
rtl/fir_sample_if.sv
rtl/fir_axil_regs.sv
rtl/fir_sample_buffer.sv
rtl/fir_mac_engine.sv
rtl/fir_stream_out.sv
rtl/fir_top.sv
sim/tb_fir.sv

// File: Makefile
SRCS := $(shell grep -v '^+' fir.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_fir: fir.f $(SRCS) rtl/fir_defs.svh
	verilator --binary --timing -Wno-fatal -f fir.f --top-module tb_fir -o Vtb_fir

run: obj_dir/Vtb_fir
	./obj_dir/Vtb_fir > sim.log 2>&1 || true
	cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
